// ==== include/board_defs.svh ====
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// serial link, 115200 baud from 50 MHz
`define SPART_DIV 434

// flops on every asynchronous input
`define SYNC_STAGES 2

// about 2 ms with no PS/2 edge inside a frame
`define PS2_TIMEOUT 100000

// set 2 make codes
`define SC_UP    8'h1D
`define SC_DOWN  8'h1B
`define SC_LEFT  8'h1C
`define SC_RIGHT 8'h23
`define SC_FIRE  8'h29
`define SC_BREAK 8'hF0

`endif

// ==== source/board_pkg.sv ====
package board_pkg;

    typedef enum logic [1:0] {
        ps2_idle,
        ps2_data,
        ps2_parity,
        ps2_stop
    } ps2_state_t;

    // shared by the tx and rx machines of spart
    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_t;

    typedef enum logic [1:0] {
        dir_up,
        dir_down,
        dir_left,
        dir_right
    } dir_t;

endpackage

// ==== source/spart_if.sv ====
interface spart_if;

    logic       tx_send;    // one cycle, ignored while busy
    logic [7:0] tx_data;
    logic       tx_busy;
    logic [7:0] rx_data;    // holds until next good byte
    logic       rx_ready;
    logic       rx_err;     // bad stop bit

    modport port (
        input  tx_send, tx_data,
        output tx_busy, rx_data, rx_ready, rx_err
    );

    modport host (
        output tx_send, tx_data,
        input  tx_busy, rx_data, rx_ready, rx_err
    );

endinterface

// ==== source/ps2_rx.sv ====
`include "board_defs.svh"

module ps2_rx (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       rx_err
);
    import board_pkg::*;

    localparam int to_w = $clog2(`PS2_TIMEOUT);
    localparam logic [to_w-1:0] to_max = to_w'(`PS2_TIMEOUT - 1);

    ps2_state_t state;
    logic [`SYNC_STAGES-1:0] clk_sync, dat_sync;
    logic clk_prev, dat_s, fall, timed_out;
    logic [7:0] shift;
    logic [2:0] bit_cnt;
    logic frame_bad;    // start or parity wrong so far
    logic [to_w-1:0] to_cnt;

    assign dat_s = dat_sync[`SYNC_STAGES-1];
    assign fall = clk_prev & ~clk_sync[`SYNC_STAGES-1];
    assign timed_out = (state != ps2_idle) && !fall && (to_cnt == to_max);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
            state <= ps2_idle;
            bit_cnt <= '0;
            frame_bad <= 1'b0;
            to_cnt <= '0;
            rx_valid <= 1'b0;
            rx_err <= 1'b0;
        end else begin
            clk_sync <= {clk_sync[`SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[`SYNC_STAGES-2:0], ps2_dat};
            clk_prev <= clk_sync[`SYNC_STAGES-1];
            rx_valid <= 1'b0;
            rx_err <= 1'b0;
            to_cnt <= (state != ps2_idle && !fall) ? to_cnt + 1'b1 : '0;
            if (timed_out) begin
                state <= ps2_idle;  // frame dropped silently
            end else if (fall) begin
                case (state)
                    ps2_idle: begin
                        frame_bad <= dat_s;     // start must be 0
                        bit_cnt <= '0;
                        state <= ps2_data;
                    end
                    ps2_data: begin
                        shift <= {dat_s, shift[7:1]};   // lsb first
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= ps2_parity;
                    end
                    ps2_parity: begin
                        frame_bad <= frame_bad | ~(^{dat_s, shift});  // odd
                        state <= ps2_stop;
                    end
                    ps2_stop: begin
                        if (frame_bad || !dat_s) begin
                            rx_err <= 1'b1;
                        end else begin
                            rx_valid <= 1'b1;
                            rx_byte <= shift;
                        end
                        state <= ps2_idle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/key_decoder.sv ====
`include "board_defs.svh"

module key_decoder (
    input  logic          sys_clk,
    input  logic          rst_n,
    input  logic [7:0]    rx_byte,
    input  logic          rx_valid,
    output board_pkg::dir_t direction,
    output logic          fire,
    output logic          done
);
    import board_pkg::*;

    logic break_seen;   // next byte is a release

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            direction <= dir_up;
            fire <= 1'b0;
            done <= 1'b0;
            break_seen <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rx_valid) begin
                if (break_seen) begin
                    break_seen <= 1'b0;
                end else begin
                    case (rx_byte)
                        `SC_BREAK: break_seen <= 1'b1;
                        `SC_UP: begin
                            direction <= dir_up;
                            fire <= 1'b0;
                            done <= 1'b1;
                        end
                        `SC_DOWN: begin
                            direction <= dir_down;
                            fire <= 1'b0;
                            done <= 1'b1;
                        end
                        `SC_LEFT: begin
                            direction <= dir_left;
                            fire <= 1'b0;
                            done <= 1'b1;
                        end
                        `SC_RIGHT: begin
                            direction <= dir_right;
                            fire <= 1'b0;
                            done <= 1'b1;
                        end
                        `SC_FIRE: begin
                            fire <= 1'b1;   // direction kept
                            done <= 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== source/spart.sv ====
`include "board_defs.svh"

module spart (
    input  logic   sys_clk,
    input  logic   rst_n,
    spart_if.port  bus,
    input  logic   rxd,
    output logic   txd
);
    import board_pkg::*;

    localparam int cw = $clog2(`SPART_DIV);
    localparam logic [cw-1:0] bit_end = cw'(`SPART_DIV - 1);
    localparam logic [cw-1:0] half_end = cw'(`SPART_DIV / 2 - 1);

    uart_state_t tx_state, rx_state;
    logic [cw-1:0] tx_cnt, rx_cnt;
    logic [2:0] tx_bit, rx_bit;
    logic [7:0] tx_shift, rx_shift;
    logic [`SYNC_STAGES-1:0] rxd_sync;
    logic rxd_s;

    assign bus.tx_busy = (tx_state != uart_idle);
    assign rxd_s = rxd_sync[`SYNC_STAGES-1];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            tx_state <= uart_idle;
            tx_cnt <= '0;
            tx_bit <= '0;
            txd <= 1'b1;
        end else begin
            tx_cnt <= (tx_state == uart_idle || tx_cnt == bit_end) ? '0 : tx_cnt + 1'b1;
            case (tx_state)
                uart_idle: if (bus.tx_send) begin
                    tx_shift <= bus.tx_data;
                    txd <= 1'b0;    // start bit
                    tx_state <= uart_start;
                end
                uart_start: if (tx_cnt == bit_end) begin
                    txd <= tx_shift[0];
                    tx_shift <= tx_shift >> 1;
                    tx_bit <= '0;
                    tx_state <= uart_data;
                end
                uart_data: if (tx_cnt == bit_end) begin
                    if (tx_bit == 3'd7) begin
                        txd <= 1'b1;
                        tx_state <= uart_stop;
                    end else begin
                        txd <= tx_shift[0];
                        tx_shift <= tx_shift >> 1;
                        tx_bit <= tx_bit + 1'b1;
                    end
                end
                uart_stop: if (tx_cnt == bit_end)
                    tx_state <= uart_idle;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rxd_sync <= '1;
            rx_state <= uart_idle;
            rx_cnt <= '0;
            rx_bit <= '0;
            bus.rx_ready <= 1'b0;
            bus.rx_err <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[`SYNC_STAGES-2:0], rxd};
            bus.rx_ready <= 1'b0;
            bus.rx_err <= 1'b0;
            rx_cnt <= rx_cnt + 1'b1;
            case (rx_state)
                uart_idle: begin
                    rx_cnt <= '0;
                    if (!rxd_s)
                        rx_state <= uart_start;
                end
                uart_start: if (rx_cnt == half_end) begin
                    rx_cnt <= '0;
                    rx_bit <= '0;
                    rx_state <= rxd_s ? uart_idle : uart_data;  // false start
                end
                uart_data: if (rx_cnt == bit_end) begin
                    rx_cnt <= '0;
                    rx_shift <= {rxd_s, rx_shift[7:1]};
                    rx_bit <= rx_bit + 1'b1;
                    if (rx_bit == 3'd7)
                        rx_state <= uart_stop;
                end
                uart_stop: if (rx_cnt == bit_end) begin
                    if (rxd_s) begin
                        bus.rx_data <= rx_shift;
                        bus.rx_ready <= 1'b1;
                    end else begin
                        bus.rx_err <= 1'b1;     // framing error, keep old byte
                    end
                    rx_state <= uart_idle;
                end
            endcase
        end
    end

endmodule

// ==== source/panel_ctrl.sv ====
module panel_ctrl (
    input  logic       sys_clk,
    input  logic       rst_n,
    spart_if.host      bus,
    input  logic       key_n,
    input  logic [7:0] sw,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic       err_led
);

    logic [2:0] key_ff;     // two to synchronize, one for the edge
    logic [7:0] shown;

    // active low segments, gfedcba
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        case (nib)
            4'h0: seg7 = 7'b1000000;
            4'h1: seg7 = 7'b1111001;
            4'h2: seg7 = 7'b0100100;
            4'h3: seg7 = 7'b0110000;
            4'h4: seg7 = 7'b0011001;
            4'h5: seg7 = 7'b0010010;
            4'h6: seg7 = 7'b0000010;
            4'h7: seg7 = 7'b1111000;
            4'h8: seg7 = 7'b0000000;
            4'h9: seg7 = 7'b0011000;
            4'hA: seg7 = 7'b0001000;
            4'hB: seg7 = 7'b0000011;
            4'hC: seg7 = 7'b1000110;
            4'hD: seg7 = 7'b0100001;
            4'hE: seg7 = 7'b0000110;
            default: seg7 = 7'b0001110;
        endcase
    endfunction

    assign bus.tx_send = key_ff[2] & ~key_ff[1];   // press = falling edge
    assign bus.tx_data = sw;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            key_ff <= 3'b111;
            shown <= '0;
            err_led <= 1'b0;
        end else begin
            key_ff <= {key_ff[1:0], key_n};
            if (bus.rx_ready)
                shown <= bus.rx_data;
            if (bus.rx_err)
                err_led <= 1'b1;    // sticky
        end
    end

    assign hex0 = seg7(shown[3:0]);
    assign hex1 = seg7(shown[7:4]);

endmodule

// ==== source/rtl_top.sv ====
module rtl_top #(
    parameter bit board_num = 0
)(
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic [3:0] key,
    input  logic [9:0] sw,
    output logic [9:0] ledr,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       uart_rxd,
    output logic       uart_txd,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5
);
    import board_pkg::*;

    logic [7:0] kb_byte;
    logic kb_valid;
    dir_t direction;
    logic fire, done, err_led;

    spart_if bus ();

    ps2_rx ps2_rx_i (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .ps2_clk(ps2_clk),
        .ps2_dat(ps2_dat),
        .rx_byte(kb_byte),
        .rx_valid(kb_valid),
        .rx_err()
    );

    key_decoder key_decoder_i (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .rx_byte(kb_byte),
        .rx_valid(kb_valid),
        .direction(direction),
        .fire(fire),
        .done(done)
    );

    spart spart_i (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .bus(bus.port),
        .rxd(uart_rxd),
        .txd(uart_txd)
    );

    panel_ctrl panel_ctrl_i (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .bus(bus.host),
        .key_n(key[1]),
        .sw(sw[7:0]),
        .hex0(hex0),
        .hex1(hex1),
        .err_led(err_led)
    );

    assign ledr[0] = (board_num == 1'b0);
    assign ledr[1] = (board_num == 1'b1);
    assign ledr[3:2] = direction;
    assign ledr[4] = fire;
    assign ledr[5] = done;
    assign ledr[8:6] = 3'b000;
    assign ledr[9] = err_led;

    // upper digits unused
    assign hex2 = 7'h7F;
    assign hex3 = 7'h7F;
    assign hex4 = 7'h7F;
    assign hex5 = 7'h7F;

endmodule

// ==== sim/board_props.sv ====
module board_props #(
    parameter bit uart_side = 1'b1
)(
    input logic sys_clk,
    input logic rst_n,
    input logic txd,
    input logic tx_busy,
    input logic rx_ready,
    input logic rx_err,
    input logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    if (uart_side) begin : uart_checks
        idle_high: assert property (
            @(posedge sys_clk) disable iff (!rst_n) !tx_busy |-> txd)
            else $error("txd low while the transmitter is idle");

        one_strobe: assert property (
            @(posedge sys_clk) disable iff (!rst_n) !(rx_ready && rx_err))
            else $error("rx_ready and rx_err high in the same cycle");
    end else begin : key_checks
        done_pulse: assert property (
            @(posedge sys_clk) disable iff (!rst_n) done |=> !done)
            else $error("done high for two cycles in a row");
    end

endmodule

bind spart board_props #(.uart_side(1'b1)) spart_props_i (
    .sys_clk(sys_clk),
    .rst_n(rst_n),
    .txd(txd),
    .tx_busy(bus.tx_busy),
    .rx_ready(bus.rx_ready),
    .rx_err(bus.rx_err),
    .done(1'b0)
);

bind key_decoder board_props #(.uart_side(1'b0)) key_props_i (
    .sys_clk(sys_clk),
    .rst_n(rst_n),
    .txd(1'b1),
    .tx_busy(1'b0),
    .rx_ready(1'b0),
    .rx_err(1'b0),
    .done(done)
);

// ==== sim/tb_top.sv ====
`include "board_defs.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import board_pkg::*;

    localparam bit board_num = 1'b1;
    localparam int bit_clks = `SPART_DIV;
    localparam int ps2_half = 20;   // clocks per PS/2 half period

    logic sys_clk;
    logic rst_n;
    logic [3:0] key;
    logic [9:0] sw;
    logic [9:0] ledr;
    logic ps2_clk;
    logic ps2_dat;
    logic uart_rxd;
    logic uart_txd;
    logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5;

    logic [31:0] lfsr = 32'h5644;
    logic [7:0] exp_shown = 8'h00;  // reference board state
    logic [1:0] exp_dir = dir_up;
    logic exp_fire = 1'b0;
    logic exp_err = 1'b0;
    logic key_brk = 1'b0;
    int chk_num = 0;
    int chk_done = 0;

    rtl_top #(.board_num(board_num)) uut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // lit segments gfedcba
    function automatic logic [6:0] seg_ref(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h67;  // no bottom bar
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;    // active low
    endfunction

    // {done, break, fire, dir} after one scan code
    function automatic logic [4:0] key_ref(input logic [3:0] st, input logic [7:0] code);
        logic brk;
        logic fire;
        logic done;
        logic [1:0] dir;
        brk = st[3];
        fire = st[2];
        dir = st[1:0];
        done = 1'b0;
        if (brk) begin
            brk = 1'b0;     // released key
        end else if (code == `SC_BREAK) begin
            brk = 1'b1;
        end else if (code == `SC_FIRE) begin
            fire = 1'b1;
            done = 1'b1;
        end else if (code == `SC_UP || code == `SC_DOWN || code == `SC_LEFT
                     || code == `SC_RIGHT) begin
            fire = 1'b0;
            done = 1'b1;
            dir = (code == `SC_UP) ? dir_up : (code == `SC_DOWN) ? dir_down
                : (code == `SC_LEFT) ? dir_left : dir_right;
        end
        return {done, brk, fire, dir};
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        stop_run($sformatf("mismatch %s got %0h expected %0h", name, got, want));
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge sys_clk);
    endtask

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge sys_clk);
            ps2_dat <= frame[i];
            tick(ps2_half / 2);
            ps2_clk <= 1'b0;
            tick(ps2_half);
            ps2_clk <= 1'b1;
            tick(ps2_half / 2);
        end
    endtask

    task automatic send_uart(input logic [7:0] data, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            uart_rxd <= frame[i];
            // short bad stop bit so the line is high before the next start check
            tick((i == 9 && bad_stop) ? bit_clks * 3 / 4 - 1 : bit_clks - 1);
        end
        @(posedge sys_clk);
        uart_rxd <= 1'b1;
    endtask

    task automatic capture_tx(output logic [9:0] frame);
        int n;
        n = 0;
        do begin
            @(posedge sys_clk);
            n++;
            assert (n < 20) else stop_run("no start bit on uart_txd after the key press");
        end while (uart_txd !== 1'b0);
        tick(bit_clks / 2);     // middle of the start bit
        for (int i = 0; i < 10; i++) begin
            frame[i] = uart_txd;
            if (i < 9)
                tick(bit_clks);
        end
    endtask

    task automatic watch_done(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < 24 * ps2_half && !seen; n++) begin
            @(posedge sys_clk);
            seen = ledr[5];
        end
    endtask

    task automatic type_key(input logic [7:0] code, input logic bad_parity);
        logic [4:0] r;
        logic seen;
        r = key_ref({key_brk, exp_fire, exp_dir}, code);
        if (bad_parity)
            r = {1'b0, key_brk, exp_fire, exp_dir};    // frame is dropped
        fork
            send_ps2(code, bad_parity);
            watch_done(seen);
        join
        assert (seen == r[4]) else report_mismatch("ledr[5]", 32'(seen), 32'(r[4]));
        key_brk = r[3];
        exp_fire = r[2];
        exp_dir = r[1:0];
        check_outputs();
    endtask

    task automatic check_outputs();
        int n;
        @(posedge sys_clk);
        chk_num <= chk_num + 1;
        n = 0;
        do begin
            @(posedge sys_clk);
            n++;
            assert (n < 10) else stop_run("compare process gave no answer");
        end while (chk_done != chk_num);
    endtask

    always @(posedge sys_clk) begin
        logic [9:0] exp_ledr;
        logic [6:0] exp_h0;
        logic [6:0] exp_h1;
        if (chk_done != chk_num) begin
            exp_ledr = {exp_err, 3'b000, 1'b0, exp_fire, exp_dir, board_num, ~board_num};
            exp_h0 = seg_ref(exp_shown[3:0]);
            exp_h1 = seg_ref(exp_shown[7:4]);
            assert (hex0 == exp_h0) else report_mismatch("hex0", 32'(hex0), 32'(exp_h0));
            assert (hex1 == exp_h1) else report_mismatch("hex1", 32'(hex1), 32'(exp_h1));
            assert ({hex5, hex4, hex3, hex2} == {4{7'h7F}})
                else report_mismatch("hex5..hex2", 32'({hex5, hex4, hex3, hex2}), 32'h0FFF_FFFF);
            assert (ledr == exp_ledr) else report_mismatch("ledr", 32'(ledr), 32'(exp_ledr));
            assert (uart_txd == 1'b1) else report_mismatch("uart_txd", 32'(uart_txd), 32'h1);
            chk_done <= chk_done + 1;
        end
    end

    initial begin
        logic [7:0] b;
        logic [9:0] frame;
        int n;
        rst_n <= 1'b0;
        key <= 4'hF;
        sw <= '0;
        ps2_clk <= 1'b1;
        ps2_dat <= 1'b1;
        uart_rxd <= 1'b1;
        tick(10);
        rst_n <= 1'b1;
        check_outputs();

        for (int r = 0; r < 4; r++) begin
            rand_byte(b);
            send_uart(b, 1'b0);
            exp_shown = b;
            check_outputs();
        end

        for (int t = 0; t < 3; t++) begin
            rand_byte(b);
            @(posedge sys_clk);
            sw <= {2'b00, b};
            key <= 4'b1101;     // button 1 pressed
            capture_tx(frame);
            assert (frame[0] == 1'b0) else report_mismatch("uart_txd start", 32'(frame[0]), 32'h0);
            assert (frame[8:1] == b) else report_mismatch("uart_txd data", 32'(frame[8:1]), 32'(b));
            assert (frame[9] == 1'b1) else report_mismatch("uart_txd stop", 32'(frame[9]), 32'h1);
            for (int i = 0; i < bit_clks; i++) begin
                @(posedge sys_clk);
                assert (uart_txd == 1'b1) else stop_run("uart_txd left idle again after one frame");
            end
            key <= 4'hF;
            check_outputs();
        end

        type_key(`SC_UP, 1'b0);
        type_key(`SC_DOWN, 1'b0);
        type_key(`SC_LEFT, 1'b0);
        type_key(`SC_RIGHT, 1'b0);
        type_key(`SC_FIRE, 1'b0);
        type_key(`SC_BREAK, 1'b0);
        type_key(`SC_UP, 1'b0);
        type_key(8'h15, 1'b0);      // not a game key
        type_key(`SC_LEFT, 1'b0);
        type_key(`SC_DOWN, 1'b1);

        send_uart(~exp_shown, 1'b1);
        exp_err = 1'b1;
        n = 0;
        while (ledr[9] !== 1'b1) begin
            @(posedge sys_clk);
            n++;
            assert (n < 2 * bit_clks) else stop_run("error LED stayed off after a bad stop bit");
        end
        check_outputs();

        $display("sim passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
source/board_pkg.sv
source/spart_if.sv
source/ps2_rx.sv
source/key_decoder.sv
source/spart.sv
source/panel_ctrl.sv
source/rtl_top.sv
sim/board_props.sv
sim/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f files.f --top-module tb_top -o tb_top_sim; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_top_sim > "$log" 2>&1; then
    cat "$log"
    echo "simulation returned an error status"
    exit 1
fi
cat "$log"

if grep -qx "sim passed" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
